/* csr_pkg.sv */
// rv32 machine mode only; no user mode, pmp or debug csrs are defined and mpp is fixed to machine
package csr_pkg;

    localparam int xlen = 32;

    // implemented machine csr addresses
    typedef enum logic [11:0] {
        csr_mstatus   = 12'h300,
        csr_misa      = 12'h301,
        csr_mie       = 12'h304,
        csr_mtvec     = 12'h305,
        csr_mscratch  = 12'h340,
        csr_mepc      = 12'h341,
        csr_mcause    = 12'h342,
        csr_mtval     = 12'h343,
        csr_mip       = 12'h344,
        csr_mcycle    = 12'hB00,
        csr_minstret  = 12'hB02,
        csr_mcycleh   = 12'hB80,
        csr_minstreth = 12'hB82,
        csr_mhartid   = 12'hF14
    } csr_addr_e;

    // payload of a system function
    typedef enum logic [11:0] {
        sys_ecall  = 12'h000,
        sys_ebreak = 12'h001,
        sys_mret   = 12'h302
    } sys_imm_e;

    typedef enum logic [1:0] {
        unit_none,
        unit_alu,
        unit_lsu,
        unit_csr
    } unit_e;

    typedef enum logic [1:0] {
        fun_sys,
        fun_rw,
        fun_rs,
        fun_rc
    } csr_fun_e;

    // misconduct reported by fetch
    typedef enum logic [1:0] {
        imiscon_none,
        imiscon_ille,
        imiscon_ferr,
        imiscon_pmav
    } imiscon_e;

    typedef enum logic [4:0] {
        exc_iaccess = 5'd1,
        exc_illegal = 5'd2,
        exc_ebreak  = 5'd3,
        exc_lmisal  = 5'd4,
        exc_laccess = 5'd5,
        exc_smisal  = 5'd6,
        exc_saccess = 5'd7,
        exc_ecall   = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        int_msi = 5'd3,
        int_mti = 5'd7,
        int_mei = 5'd11
    } int_code_e;

    localparam logic [1:0] lsu_half = 2'd1; // function_i[1:0] of the lsu
    localparam logic [1:0] lsu_word = 2'd2;

    localparam int irq_msi_bit      = 3;
    localparam int irq_mti_bit      = 7;
    localparam int irq_mei_bit      = 11;
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;

    localparam logic [xlen-1:0] misa_val         = 32'h4000_1104; // rv32 imc
    localparam logic [xlen-1:0] mie_mask         = 32'h0000_0888; // also mpie/mie in mstatus
    localparam logic [xlen-1:0] mstatus_rd_fixed = 32'h0000_1800; // mpp reads as machine

endpackage

/* csr_decode.sv */
// purely combinational; lsu size sits in function_i[1:0] with store in bit 3, rstpp_i stops every trap
`timescale 1ns/10ps

module csr_decode import csr_pkg::*; (
    input  unit_e           unit_i,
    input  logic [3:0]      function_i,
    input  logic [11:0]     payload_i,
    input  logic [xlen-1:0] val_i,
    input  imiscon_e        imiscon_i,
    input  logic            hresp_i,
    input  logic            stall_i,
    input  logic            flush_i,
    input  logic            rstpp_i,
    output logic            csr_wr_o,
    output csr_addr_e       csr_addr_o,
    output csr_fun_e        csr_fun_o,
    output logic            mret_o,
    output logic            commit_o,
    output logic            exception_o,
    output logic            exc_active_ready_o,
    output exc_code_e       exc_code_o
);
    logic is_lsu;
    logic pmav;
    logic sys_op;
    logic misaligned;
    logic e_iacc;
    logic e_ill;
    logic e_ecall;
    logic e_ebreak;
    logic e_misal;
    logic e_lsacc;
    logic execute;

    assign is_lsu     = (unit_i == unit_lsu);
    assign pmav       = (imiscon_i == imiscon_pmav);
    assign misaligned = ((function_i[1:0] == lsu_half) & val_i[0]) |
                        ((function_i[1:0] == lsu_word) & (|val_i[1:0]));

    always_comb begin : strobe_gen
        sys_op   = (unit_i == unit_csr) & (function_i[2:0] == 3'b000);
        csr_wr_o = (unit_i == unit_csr) & (function_i[1:0] != fun_sys) & ~flush_i;
        mret_o   = sys_op & (payload_i == sys_mret) & ~flush_i;
    end

    assign e_iacc   = (imiscon_i == imiscon_ferr) | (pmav & ~is_lsu);
    assign e_ill    = (imiscon_i == imiscon_ille);
    assign e_ecall  = sys_op & (payload_i == sys_ecall);
    assign e_ebreak = sys_op & (payload_i == sys_ebreak);
    assign e_misal  = is_lsu & misaligned;
    assign e_lsacc  = is_lsu & (hresp_i | pmav);

    assign exception_o = e_iacc | e_ill | e_ecall | e_ebreak | e_misal | e_lsacc;
    assign execute     = ((unit_i != unit_none) | e_iacc | e_ill) & ~rstpp_i;
    assign exc_active_ready_o = exception_o & execute;

    assign commit_o   = (unit_i != unit_none) & ~stall_i & ~flush_i; // minstret tick
    assign csr_addr_o = csr_addr_e'(payload_i);
    assign csr_fun_o  = csr_fun_e'(function_i[1:0]);

    // highest priority first with the access fault as fallback
    always_comb begin : exc_prio
        if (e_iacc) begin
            exc_code_o = exc_iaccess;
        end else if (e_ill) begin
            exc_code_o = exc_illegal;
        end else if (e_ecall) begin
            exc_code_o = exc_ecall;
        end else if (e_ebreak) begin
            exc_code_o = exc_ebreak;
        end else if (e_misal) begin
            exc_code_o = function_i[3] ? exc_smisal : exc_lmisal;
        end else begin
            exc_code_o = function_i[3] ? exc_saccess : exc_laccess;
        end
    end

endmodule

/* csr_trap_ctrl.sv */
// combinational; only msi, mti and mei are known, vectored mode adds four times the code to the base
`timescale 1ns/10ps

module csr_trap_ctrl import csr_pkg::*; (
    input  logic [xlen-1:0] mie_i,
    input  logic [xlen-1:0] mip_i,
    input  logic            mstatus_mie_i,
    input  logic [xlen-1:0] mtvec_i,
    input  logic            interrupted_i,
    input  logic            exc_active_ready_i,
    output logic            int_pending_o,
    output int_code_e       int_code_o,
    output logic            trap_take_o,
    output logic            exc_take_o,
    output logic [xlen-1:0] exc_trap_o,
    output logic [xlen-1:0] int_trap_o
);
    logic [xlen-1:0] pend;
    logic [xlen-1:0] int_vect;

    assign pend          = mie_i & mip_i;
    assign int_pending_o = (|pend) & mstatus_mie_i;

    // ranking mei > msi > mti
    always_comb begin : int_rank
        if (pend[irq_mei_bit]) begin
            int_code_o = int_mei;
        end else if (pend[irq_msi_bit]) begin
            int_code_o = int_msi;
        end else begin
            int_code_o = int_mti;
        end
    end

    // an interrupt taken in the same cycle wins over the exception
    assign trap_take_o = interrupted_i | exc_active_ready_i;
    assign exc_take_o  = exc_active_ready_i & ~interrupted_i;

    assign exc_trap_o = {mtvec_i[xlen-1:2], 2'b00};
    assign int_vect   = exc_trap_o + {{(xlen-7){1'b0}}, int_code_o, 2'b00};
    assign int_trap_o = mtvec_i[0] ? int_vect : exc_trap_o; // mode bit

    // the core may only take what this unit reported as pending
    always_comb begin : chk_int_ack
        if (interrupted_i) begin
            assert (int_pending_o) else $error("csr_trap_ctrl: interrupt taken, none pending");
        end
    end

endmodule

/* csr_counters.sv */
// both counters are 64 bit and free running; a write replaces one half for one edge only
`timescale 1ns/10ps

module csr_counters import csr_pkg::*; (
    input  logic            s_clk_i,
    input  logic            arst_n_i,
    input  logic            csr_wr_i,
    input  csr_addr_e       csr_addr_i,
    input  logic [xlen-1:0] wdata_i,
    input  logic            commit_i,
    output logic [63:0]     mcycle_o,
    output logic [63:0]     minstret_o
);
    logic [63:0] mcycle_q;
    logic [63:0] minstret_q;

    // next count, a written half takes the csr value instead of the sum
    function automatic logic [63:0] cnt_next(
        input logic [63:0]     cur,
        input logic            inc,
        input logic            wr_lo,
        input logic            wr_hi,
        input logic [xlen-1:0] wdata
    );
        logic [63:0] nxt;
        nxt = inc ? cur + 64'd1 : cur;
        if (wr_lo) begin
            nxt[xlen-1:0] = wdata;
        end
        if (wr_hi) begin
            nxt[63:xlen] = wdata;
        end
        return nxt;
    endfunction

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q   <= cnt_next(mcycle_q, 1'b1,
                                   csr_wr_i & (csr_addr_i == csr_mcycle),
                                   csr_wr_i & (csr_addr_i == csr_mcycleh), wdata_i);
            minstret_q <= cnt_next(minstret_q, commit_i,
                                   csr_wr_i & (csr_addr_i == csr_minstret),
                                   csr_wr_i & (csr_addr_i == csr_minstreth), wdata_i);
        end
    end

    assign mcycle_o   = mcycle_q;
    assign minstret_o = minstret_q;

endmodule

/* csr_regs.sv */
// machine csrs only; unknown addresses read zero and writes to them are dropped, traps beat csr writes
`timescale 1ns/10ps

module csr_regs import csr_pkg::*; (
    input  logic            s_clk_i,
    input  logic            arst_n_i,
    input  logic            csr_wr_i,
    input  csr_addr_e       csr_addr_i,
    input  csr_fun_e        csr_fun_i,
    input  logic            mret_i,
    input  logic            trap_take_i,
    input  logic            exc_take_i,
    input  logic            interrupted_i,
    input  int_code_e       int_code_i,
    input  exc_code_e       exc_code_i,
    input  logic [xlen-1:0] val_i,
    input  logic [xlen-1:0] pc_i,
    input  logic            int_meip_i,
    input  logic            int_mtip_i,
    input  logic            int_msip_i,
    input  logic [63:0]     mcycle_i,
    input  logic [63:0]     minstret_i,
    output logic [xlen-1:0] rdata_o,
    output logic [xlen-1:0] wdata_o,
    output logic [xlen-1:0] mie_o,
    output logic [xlen-1:0] mip_o,
    output logic            mstatus_mie_o,
    output logic [xlen-1:0] mtvec_o,
    output logic [xlen-1:0] mepc_o
);
    logic [xlen-1:0] mstatus_q;
    logic [xlen-1:0] mie_q;
    logic [xlen-1:0] mip_q;
    logic [xlen-1:0] mip_d;
    logic [xlen-1:0] mtvec_q;
    logic [xlen-1:0] mscratch_q;
    logic [xlen-1:0] mepc_q;
    logic [xlen-1:0] mcause_q;
    logic [xlen-1:0] mtval_q;
    logic [4:0]      cause_code;

    always_comb begin : rd_mux
        case (csr_addr_i)
            csr_mstatus:   rdata_o = mstatus_q | mstatus_rd_fixed;
            csr_misa:      rdata_o = misa_val;
            csr_mie:       rdata_o = mie_q;
            csr_mtvec:     rdata_o = mtvec_q;
            csr_mscratch:  rdata_o = mscratch_q;
            csr_mepc:      rdata_o = mepc_q;
            csr_mcause:    rdata_o = mcause_q;
            csr_mtval:     rdata_o = mtval_q;
            csr_mip:       rdata_o = mip_q;
            csr_mcycle:    rdata_o = mcycle_i[xlen-1:0];
            csr_mcycleh:   rdata_o = mcycle_i[63:xlen];
            csr_minstret:  rdata_o = minstret_i[xlen-1:0];
            csr_minstreth: rdata_o = minstret_i[63:xlen];
            default:       rdata_o = '0; // mhartid and unmapped
        endcase
    end

    // read-modify-write value
    always_comb begin : rmw
        case (csr_fun_i)
            fun_rw:  wdata_o = val_i;
            fun_rs:  wdata_o = val_i | rdata_o;
            fun_rc:  wdata_o = ~val_i & rdata_o;
            default: wdata_o = rdata_o;
        endcase
    end

    // level inputs sampled every cycle
    always_comb begin : mip_sample
        mip_d              = '0;
        mip_d[irq_mei_bit] = int_meip_i;
        mip_d[irq_mti_bit] = int_mtip_i;
        mip_d[irq_msi_bit] = int_msip_i;
    end

    always_comb begin : cause_sel
        if (interrupted_i) begin
            cause_code = int_code_i;
        end else begin
            cause_code = exc_code_i;
        end
    end

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mstatus_q <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
            mtval_q   <= '0;
        end else begin
            if (trap_take_i) begin
                mstatus_q[mstatus_mpie_bit] <= mstatus_q[mstatus_mie_bit];
                mstatus_q[mstatus_mie_bit]  <= 1'b0;
                mepc_q   <= pc_i;
                mcause_q <= {interrupted_i, {(xlen-6){1'b0}}, cause_code};
            end else if (mret_i) begin
                mstatus_q[mstatus_mpie_bit] <= 1'b1;
                mstatus_q[mstatus_mie_bit]  <= mstatus_q[mstatus_mpie_bit];
            end else if (csr_wr_i) begin
                if (csr_addr_i == csr_mstatus) begin
                    mstatus_q <= wdata_o & mie_mask & ~mstatus_rd_fixed; // mpp stays fixed
                end
                if (csr_addr_i == csr_mepc) begin
                    mepc_q <= wdata_o;
                end
                if (csr_addr_i == csr_mcause) begin
                    mcause_q <= wdata_o;
                end
            end
            if (exc_take_i) begin
                mtval_q <= val_i;
            end else if (csr_wr_i && (csr_addr_i == csr_mtval)) begin
                mtval_q <= wdata_o;
            end
        end
    end

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mie_q      <= '0;
            mip_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
        end else begin
            mip_q <= mip_d;
            if (csr_wr_i && (csr_addr_i == csr_mie)) begin
                mie_q <= wdata_o & mie_mask;
            end
            if (csr_wr_i && (csr_addr_i == csr_mtvec)) begin
                mtvec_q <= {wdata_o[xlen-1:2], 1'b0, wdata_o[0]}; // only direct and vectored modes
            end
            if (csr_wr_i && (csr_addr_i == csr_mscratch)) begin
                mscratch_q <= wdata_o;
            end
        end
    end

    assign mie_o         = mie_q;
    assign mip_o         = mip_q;
    assign mstatus_mie_o = mstatus_q[mstatus_mie_bit];
    assign mtvec_o       = mtvec_q;
    assign mepc_o        = mepc_q;

    // mtval and the cause record must move together
    a_exc_in_trap: assert property (@(posedge s_clk_i) disable iff (!arst_n_i)
                                    exc_take_i |-> trap_take_i);
    a_exc_tval:    assert property (@(posedge s_clk_i) disable iff (!arst_n_i)
                                    (trap_take_i && !interrupted_i) |-> exc_take_i);

endmodule

/* csr_unit.sv */
// memory-access stage csr unit; every output settles in the same cycle, no internal pipeline registers
`timescale 1ns/10ps

module csr_unit import csr_pkg::*; (
    input  logic            s_clk_i,
    input  logic            arst_n_i,
    input  unit_e           unit_i,
    input  logic [3:0]      function_i,
    input  logic [11:0]     payload_i,
    input  logic [xlen-1:0] val_i,
    input  logic [xlen-1:0] pc_i,
    input  imiscon_e        imiscon_i,
    input  logic            hresp_i,
    input  logic            stall_i,
    input  logic            flush_i,
    input  logic            rstpp_i,
    input  logic            interrupted_i,
    input  logic            int_meip_i,
    input  logic            int_mtip_i,
    input  logic            int_msip_i,
    output logic [xlen-1:0] csr_rdata_o,
    output logic [xlen-1:0] exc_trap_o,
    output logic [xlen-1:0] int_trap_o,
    output logic [xlen-1:0] mepc_o,
    output logic            treturn_o,
    output logic            int_pending_o,
    output logic            exception_o
);
    logic            csr_wr;
    csr_addr_e       csr_addr;
    csr_fun_e        csr_fun;
    logic            mret;
    logic            commit;
    logic            exc_active_ready;
    exc_code_e       exc_code;
    int_code_e       int_code;
    logic            trap_take;
    logic            exc_take;
    logic [xlen-1:0] mie;
    logic [xlen-1:0] mip;
    logic            mstatus_mie;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] wdata;
    logic [63:0]     mcycle;
    logic [63:0]     minstret;

    assign treturn_o = mret;

    csr_decode u_decode (
        .unit_i(unit_i), .function_i(function_i), .payload_i(payload_i), .val_i(val_i),
        .imiscon_i(imiscon_i), .hresp_i(hresp_i), .stall_i(stall_i), .flush_i(flush_i),
        .rstpp_i(rstpp_i), .csr_wr_o(csr_wr), .csr_addr_o(csr_addr), .csr_fun_o(csr_fun),
        .mret_o(mret), .commit_o(commit), .exception_o(exception_o),
        .exc_active_ready_o(exc_active_ready), .exc_code_o(exc_code)
    );

    csr_trap_ctrl u_trap_ctrl (
        .mie_i(mie), .mip_i(mip), .mstatus_mie_i(mstatus_mie), .mtvec_i(mtvec),
        .interrupted_i(interrupted_i), .exc_active_ready_i(exc_active_ready),
        .int_pending_o(int_pending_o), .int_code_o(int_code), .trap_take_o(trap_take),
        .exc_take_o(exc_take), .exc_trap_o(exc_trap_o), .int_trap_o(int_trap_o)
    );

    csr_regs u_regs (
        .s_clk_i(s_clk_i), .arst_n_i(arst_n_i), .csr_wr_i(csr_wr), .csr_addr_i(csr_addr),
        .csr_fun_i(csr_fun), .mret_i(mret), .trap_take_i(trap_take), .exc_take_i(exc_take),
        .interrupted_i(interrupted_i), .int_code_i(int_code), .exc_code_i(exc_code),
        .val_i(val_i), .pc_i(pc_i), .int_meip_i(int_meip_i), .int_mtip_i(int_mtip_i),
        .int_msip_i(int_msip_i), .mcycle_i(mcycle), .minstret_i(minstret),
        .rdata_o(csr_rdata_o), .wdata_o(wdata), .mie_o(mie), .mip_o(mip),
        .mstatus_mie_o(mstatus_mie), .mtvec_o(mtvec), .mepc_o(mepc_o)
    );

    csr_counters u_counters (
        .s_clk_i(s_clk_i), .arst_n_i(arst_n_i), .csr_wr_i(csr_wr), .csr_addr_i(csr_addr),
        .wdata_i(wdata), .commit_i(commit), .mcycle_o(mcycle), .minstret_o(minstret)
    );

endmodule

/* tb_csr_model.svh */
// reference model for the csr testbench; covers only the machine csrs and non-csr exception sources
`ifndef TB_CSR_MODEL_SVH
`define TB_CSR_MODEL_SVH

// rw 1, rs 2, rc 3
function automatic logic [31:0] rmw_result(input logic [1:0] fun, input logic [31:0] old,
                                           input logic [31:0] v);
    case (fun)
        2'd1:    return v;
        2'd2:    return old | v;
        2'd3:    return old & ~v;
        default: return old;
    endcase
endfunction

// value that lands in the register after a write
function automatic logic [31:0] stored_value(input logic [11:0] addr, input logic [31:0] w);
    case (addr)
        12'h300: return w & 32'h0000_0088; // mpie and mie only
        12'h304: return w & 32'h0000_0888;
        12'h305: return w & ~32'h2;
        default: return w;
    endcase
endfunction

function automatic logic [31:0] csr_read_value(input logic [11:0] addr,
                                               input logic [31:0] mstatus,
                                               input logic [31:0] mie, input logic [31:0] mtvec,
                                               input logic [31:0] mscratch,
                                               input logic [31:0] mepc,
                                               input logic [31:0] mcause,
                                               input logic [31:0] mtval);
    case (addr)
        12'h300: return mstatus | 32'h0000_1800;
        12'h301: return 32'h4000_1104;
        12'h304: return mie;
        12'h305: return mtvec;
        12'h340: return mscratch;
        12'h341: return mepc;
        12'h342: return mcause;
        12'h343: return mtval;
        default: return 32'h0; // mhartid too
    endcase
endfunction

// {raised, cause} for alu, lsu or empty slots
function automatic logic [5:0] exception_cause(input logic [1:0] u, input logic [3:0] f,
                                               input logic [1:0] im, input logic hr,
                                               input logic [31:0] a);
    logic lsu;
    logic misal;
    lsu   = (u == 2'd2);
    misal = lsu && ((f[1:0] == 2'd1 && a[0]) || (f[1:0] == 2'd2 && a[1:0] != 2'b00));
    if (im == 2'd2 || (im == 2'd3 && !lsu)) return {1'b1, 5'd1};
    if (im == 2'd1) return {1'b1, 5'd2};
    if (misal) return {1'b1, f[3] ? 5'd6 : 5'd4};
    if (lsu && (hr || im == 2'd3)) return {1'b1, f[3] ? 5'd7 : 5'd5};
    return 6'd0;
endfunction

// src is {mei, mti, msi}
function automatic logic [4:0] ranked_int_code(input logic [2:0] src);
    if (src[2]) return 5'd11;
    if (src[0]) return 5'd3;
    return 5'd7;
endfunction

// mode bits dropped
function automatic logic [31:0] mtvec_base(input logic [31:0] mtvec);
    return mtvec & 32'hFFFF_FFFC;
endfunction

// vectored mode adds four bytes per cause code
function automatic logic [31:0] int_vector_addr(input logic [31:0] mtvec,
                                                input logic [4:0] code);
    if (mtvec[0]) return mtvec_base(mtvec) + 32'(code) * 32'd4;
    return mtvec_base(mtvec);
endfunction

`endif

/* tb_csr_unit.sv */
// self-checking testbench; stops at the first mismatch, counters are checked by differences only
`timescale 1ns/10ps

module tb_csr_unit;
    import csr_pkg::*;
    `include "tb_csr_model.svh"

    localparam int clk_period  = 4;
    localparam int n_rmw       = 40;
    localparam int n_exc       = 40;
    localparam int n_cnt       = 30;
    localparam int test_cycles = 8 + n_rmw * 2 + n_exc * 4 + 60 + 2 * n_cnt + 20;

    logic clk;
    logic arst_n;
    unit_e unit;
    logic [3:0] func;
    logic [11:0] payload;
    logic [31:0] val;
    logic [31:0] pc;
    imiscon_e imiscon;
    logic hresp, stall, flush, rstpp, intr;
    logic meip, mtip, msip;
    logic [31:0] csr_rdata_o, exc_trap_o, int_trap_o, mepc_o;
    logic treturn_o, int_pending_o, exception_o;

    logic [31:0] m_mstatus, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval; // model state
    string tname;
    logic chk_rd, chk_exc, chk_int, chk_itrap, chk_state;
    logic exp_exc, exp_tret, exp_int;
    logic [31:0] exp_rd, exp_itrap, exp_mepc, exp_etrap;
    integer seed = 32'hb83fd225;

    csr_unit dut (
        .s_clk_i(clk), .arst_n_i(arst_n), .unit_i(unit), .function_i(func),
        .payload_i(payload), .val_i(val), .pc_i(pc), .imiscon_i(imiscon), .hresp_i(hresp),
        .stall_i(stall), .flush_i(flush), .rstpp_i(rstpp), .interrupted_i(intr),
        .int_meip_i(meip), .int_mtip_i(mtip), .int_msip_i(msip),
        .csr_rdata_o(csr_rdata_o), .exc_trap_o(exc_trap_o), .int_trap_o(int_trap_o),
        .mepc_o(mepc_o), .treturn_o(treturn_o), .int_pending_o(int_pending_o),
        .exception_o(exception_o)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] e, input logic [31:0] a);
        $display("FAIL %s expected %h actual %h", name, e, a);
        $display("TEST FAILED");
        $fatal(1, "stopping at first mismatch");
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            if (chk_rd) assert (csr_rdata_o === exp_rd)
                else report_mismatch(tname, exp_rd, csr_rdata_o);
            if (chk_exc) assert (exception_o === exp_exc)
                else report_mismatch({tname, " exception"}, 32'(exp_exc), 32'(exception_o));
            if (chk_exc) assert (treturn_o === exp_tret)
                else report_mismatch({tname, " treturn"}, 32'(exp_tret), 32'(treturn_o));
            if (chk_int) assert (int_pending_o === exp_int)
                else report_mismatch({tname, " pending"}, 32'(exp_int), 32'(int_pending_o));
            if (chk_itrap) assert (int_trap_o === exp_itrap)
                else report_mismatch({tname, " int_trap"}, exp_itrap, int_trap_o);
            if (chk_state) assert (mepc_o === exp_mepc)
                else report_mismatch({tname, " mepc_o"}, exp_mepc, mepc_o);
            if (chk_state) assert (exc_trap_o === exp_etrap)
                else report_mismatch({tname, " exc_trap"}, exp_etrap, exc_trap_o);
        end
    end

    initial begin
        #(test_cycles * clk_period + 200);
        $display("watchdog: the run went past its cycle budget");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    function automatic logic [31:0] predicted_read(input logic [11:0] addr);
        return csr_read_value(addr, m_mstatus, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause,
                              m_mtval);
    endfunction

    task automatic apply_write(input logic [11:0] addr, input logic [31:0] w);
        case (addr)
            12'h300: m_mstatus = w;
            12'h304: m_mie = w;
            12'h305: m_mtvec = w;
            12'h340: m_mscratch = w;
            12'h341: m_mepc = w;
            12'h342: m_mcause = w;
            12'h343: m_mtval = w;
            default: ;
        endcase
    endtask

    task automatic enter_trap(input logic [31:0] tpc, input logic [31:0] cause,
                              input logic wr_tval, input logic [31:0] tval);
        m_mepc = tpc;
        m_mcause = cause;
        if (wr_tval) m_mtval = tval;
        m_mstatus = {24'd0, m_mstatus[3], 3'd0, 1'b0, 3'd0}; // mie to mpie
    endtask

    // default inputs for one cycle while interrupt lines keep their level
    task automatic idle();
        unit <= unit_none;
        func <= 4'd0;
        payload <= 12'd0;
        val <= 32'd0;
        pc <= 32'd0;
        imiscon <= imiscon_none;
        hresp <= 1'b0;
        stall <= 1'b0;
        flush <= 1'b0;
        rstpp <= 1'b0;
        intr <= 1'b0;
        chk_rd = 1'b0;
        chk_exc = 1'b0;
        chk_int = 1'b0;
        chk_itrap = 1'b0;
        chk_state = 1'b0;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        idle();
    endtask

    task automatic csr_op(input csr_fun_e fun, input logic [11:0] addr, input logic [31:0] v,
                          input logic chk, input string name);
        logic [31:0] old;
        old = predicted_read(addr);
        @(posedge clk);
        idle();
        unit <= unit_csr;
        func <= {2'b00, fun};
        payload <= addr;
        val <= v;
        tname = name;
        chk_rd = chk;
        exp_rd = old;
        chk_exc = 1'b1;
        exp_exc = 1'b0;
        exp_tret = 1'b0;
        apply_write(addr, stored_value(addr, rmw_result(fun, old, v)));
    endtask

    // sys function with a csr address reads without writing
    task automatic read_csr(input logic [11:0] addr, input logic chk, input logic [31:0] expv,
                            input string name, output logic [31:0] got);
        @(posedge clk);
        idle();
        unit <= unit_csr;
        payload <= addr;
        tname = name;
        chk_rd = chk;
        exp_rd = expv;
        chk_state = 1'b1;
        exp_mepc = m_mepc;
        exp_etrap = mtvec_base(m_mtvec);
        @(negedge clk);
        got = csr_rdata_o;
    endtask

    task automatic check_reg(input logic [11:0] addr, input string name);
        logic [31:0] dummy;
        read_csr(addr, 1'b1, predicted_read(addr), name, dummy);
    endtask

    task automatic sys_op(input logic [11:0] imm, input logic fl, input string name);
        @(posedge clk);
        idle();
        unit <= unit_csr;
        payload <= imm;
        flush <= fl;
        pc <= 32'h8000_0040;
        val <= 32'h0000_0055;
        tname = name;
        chk_exc = 1'b1;
        exp_exc = (imm == 12'h000);
        exp_tret = (imm == 12'h302) && !fl;
        if (imm == 12'h000) enter_trap(32'h8000_0040, 32'd11, 1'b1, 32'h55);
        if (exp_tret) m_mstatus = {24'd0, 1'b1, 3'd0, m_mstatus[7], 3'd0};
    endtask

    task automatic irq_take(input logic [2:0] src, input string name);
        logic [4:0] code;
        logic [31:0] p;
        code = ranked_int_code(src);
        p = $random(seed);
        @(posedge clk);
        idle();
        {meip, mtip, msip} <= src;
        tname = name;
        chk_int = 1'b1;
        exp_int = 1'b0; // mip samples at the next edge
        @(posedge clk);
        idle();
        intr <= 1'b1;
        pc <= p;
        chk_int = 1'b1;
        exp_int = 1'b1;
        chk_itrap = 1'b1;
        exp_itrap = int_vector_addr(m_mtvec, code);
        enter_trap(p, {1'b1, 26'd0, code}, 1'b0, 32'd0);
        @(posedge clk);
        idle();
        {meip, mtip, msip} <= 3'b000;
        chk_int = 1'b1;
        exp_int = 1'b0;
        check_reg(12'h342, {name, " mcause"});
        check_reg(12'h341, {name, " mepc"});
    endtask

    initial begin
        logic [11:0] rmw_addr [4];
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] p;
        logic [31:0] c1;
        logic [31:0] c2;
        logic [5:0]  ex;
        logic [3:0]  f;
        logic        rs;
        int          n;

        rmw_addr = '{12'h340, 12'h305, 12'h304, 12'h300};
        {m_mstatus, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval} = '0;
        arst_n = 1'b0;
        {meip, mtip, msip} = 3'b000;
        unit = unit_none;
        func = 4'd0;
        payload = 12'd0;
        {val, pc} = '0;
        imiscon = imiscon_none;
        {hresp, stall, flush, rstpp, intr} = '0;
        {chk_rd, chk_exc, chk_int, chk_itrap, chk_state} = '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        check_reg(12'h301, "misa");
        check_reg(12'hF14, "mhartid");
        for (int i = 0; i < n_rmw; i++) begin
            r = $random(seed);
            a = $random(seed);
            csr_op(csr_fun_e'(2'd1 + 2'(r[1:0] % 3)), rmw_addr[r[3:2]], a, 1'b1, "rmw old");
            check_reg(rmw_addr[r[3:2]], "rmw new");
        end

        for (int i = 0; i < n_exc; i++) begin
            r = $random(seed);
            a = $random(seed);
            p = $random(seed);
            f = {r[4], 1'b0, r[6:5]};
            rs = (r[12:11] == 2'b00);
            ex = exception_cause(2'(r[7:0] % 3), f, r[9:8], r[10] & r[13], a);
            @(posedge clk);
            idle();
            unit <= unit_e'(2'(r[7:0] % 3));
            func <= f;
            imiscon <= imiscon_e'(r[9:8]);
            hresp <= r[10] & r[13];
            rstpp <= rs;
            val <= a;
            pc <= p;
            tname = "exception";
            chk_exc = 1'b1;
            exp_exc = ex[5];
            exp_tret = 1'b0;
            if (ex[5] && !rs) enter_trap(p, {27'd0, ex[4:0]}, 1'b1, a);
            check_reg(12'h342, "exc mcause");
            check_reg(12'h341, "exc mepc");
            check_reg(12'h343, "exc mtval");
        end

        csr_op(fun_rs, 12'h300, 32'h8, 1'b1, "enable mie");
        sys_op(12'h000, 1'b0, "ecall");
        check_reg(12'h300, "ecall mstatus");
        check_reg(12'h342, "ecall mcause");
        sys_op(12'h302, 1'b0, "mret");
        check_reg(12'h300, "mret mstatus");
        csr_op(fun_rc, 12'h300, 32'h8, 1'b1, "clear mie");
        sys_op(12'h302, 1'b1, "flushed mret");
        check_reg(12'h300, "flushed mret mstatus");

        csr_op(fun_rw, 12'h305, 32'h0000_0101, 1'b1, "mtvec vectored");
        csr_op(fun_rw, 12'h304, 32'hFFFF_FFFF, 1'b1, "mie all");
        csr_op(fun_rs, 12'h300, 32'h8, 1'b1, "irq enable");
        irq_take(3'b011, "irq msi over mti");
        csr_op(fun_rs, 12'h300, 32'h8, 1'b1, "irq enable");
        irq_take(3'b010, "irq mti");
        csr_op(fun_rs, 12'h300, 32'h8, 1'b1, "irq enable");
        irq_take(3'b111, "irq mei first");
        csr_op(fun_rw, 12'h305, 32'h0000_0200, 1'b1, "mtvec direct");
        csr_op(fun_rs, 12'h300, 32'h8, 1'b1, "irq enable");
        irq_take(3'b100, "irq direct");

        read_csr(12'hB00, 1'b0, 32'd0, "mcycle base", c1);
        repeat (n_cnt) idle_cycle();
        read_csr(12'hB00, 1'b1, c1 + n_cnt + 1, "mcycle delta", c2);
        read_csr(12'hB02, 1'b0, 32'd0, "minstret base", c1);
        n = 1; // the base read commits too
        for (int i = 0; i < n_cnt; i++) begin
            r = $random(seed);
            @(posedge clk);
            idle();
            unit <= r[0] ? unit_alu : unit_none;
            stall <= r[1];
            flush <= r[2];
            if (r[0] && !r[1] && !r[2]) n++;
        end
        read_csr(12'hB02, 1'b1, c1 + 32'(n), "minstret delta", c2);
        csr_op(fun_rw, 12'hB80, 32'h1234_5678, 1'b0, "mcycleh write");
        read_csr(12'hB80, 1'b1, 32'h1234_5678, "mcycleh readback", c2);
        idle_cycle();
        @(negedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* csr_unit.f */
+incdir+.
csr_pkg.sv
csr_decode.sv
csr_trap_ctrl.sv
csr_counters.sv
csr_regs.sv
csr_unit.sv
tb_csr_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_csr_unit
DUT       ?= csr_unit
FLIST     ?= csr_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(DUT) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
